// ==== Makefile ====
# Verilator build and run of the radio front-end testbench

TOP = tb_radio_frontend_top
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f radio_frontend_top.f -Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	@cat $(LOG)
	@! grep -q "Regression failed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== lms_rx_deinterleave.sv ====
//--------------------
// Receive capture from the transceiver's two time-interleaved ADCs.
// Drives the I/Q select pins and hands zero-extended I/Q pairs to
// the DSP with a one-cycle strobe, one pair every second cycle.
//--------------------
module lms_rx_deinterleave
(
   input  logic                           dsp_clk,
   input  logic                           reset_i,
   input  radio_frontend_pkg::adc_word_t  adc0_i,
   input  radio_frontend_pkg::adc_word_t  adc1_i,
   output logic                           rx_iq_sel0_o,
   output logic                           rx_iq_sel1_o,
   output radio_frontend_pkg::rx_sample_t adc_i0_o,
   output radio_frontend_pkg::rx_sample_t adc_q0_o,
   output radio_frontend_pkg::rx_sample_t adc_i1_o,
   output radio_frontend_pkg::rx_sample_t adc_q1_o,
   output logic                           adc_strobe_o
);
   import radio_frontend_pkg::*;

   iq_phase_e phase_q;             // Shared by both channels
   iq_phase_e phase_next;
   logic      sel0_q;
   logic      sel1_q;
   adc_word_t hold_i0_q;           // I words waiting for their Q
   adc_word_t hold_i1_q;

   assign phase_next = (phase_q == IQ_PHASE_I) ? IQ_PHASE_Q : IQ_PHASE_I;

   // Phase and select pins
   // One flop per select pin so each can sit next to its pad
   always_ff @(posedge dsp_clk)
   begin
      if (reset_i)
      begin
         phase_q <= IQ_PHASE_I;
         sel0_q  <= 1'b0;
         sel1_q  <= 1'b0;
      end
      else
      begin
         phase_q <= phase_next;
         sel0_q  <= (phase_next == IQ_PHASE_Q);  // Low while I is wanted
         sel1_q  <= (phase_next == IQ_PHASE_Q);
      end
   end

   assign rx_iq_sel0_o = sel0_q;
   assign rx_iq_sel1_o = sel1_q;

   // Hold the I words for one cycle
   always_ff @(posedge dsp_clk)
   begin
      if (phase_q == IQ_PHASE_I)
      begin
         hold_i0_q <= adc0_i;
         hold_i1_q <= adc1_i;
      end
   end

   // Pair output, Q taken straight off the pins
   always_ff @(posedge dsp_clk)
   begin
      if (reset_i)
      begin
         adc_strobe_o <= 1'b0;
         adc_i0_o     <= '0;
         adc_q0_o     <= '0;
         adc_i1_o     <= '0;
         adc_q1_o     <= '0;
      end
      else
      begin
         adc_strobe_o <= (phase_q == IQ_PHASE_Q);
         if (phase_q == IQ_PHASE_Q)
         begin
            adc_i0_o <= rx_sample_t'(hold_i0_q);  // Zero-extend
            adc_q0_o <= rx_sample_t'(adc0_i);
            adc_i1_o <= rx_sample_t'(hold_i1_q);
            adc_q1_o <= rx_sample_t'(adc1_i);
         end
      end
   end

   // A pair takes two cycles on the pins
   strobe_spacing_a : assert property (
      @(posedge dsp_clk) disable iff (reset_i)
      adc_strobe_o |=> !adc_strobe_o
   );

   // Both transceiver channels must see the same phase
   sel_match_a : assert property (
      @(posedge dsp_clk) rx_iq_sel0_o == rx_iq_sel1_o
   );

endmodule

// ==== lms_tx_interleave.sv ====
//--------------------
// Transmit serializer for the transceiver's single DAC bus.
// An I/Q pair from the DSP is sampled every second cycle; I goes
// out with the select low, then Q with the select high.
//--------------------
module lms_tx_interleave
(
   input  logic                            dsp_clk,
   input  logic                            reset_i,
   input  radio_frontend_pkg::dac_sample_t dac_i_i,
   input  radio_frontend_pkg::dac_sample_t dac_q_i,
   output radio_frontend_pkg::dac_word_t   dac_o,
   output logic                            tx_iq_sel_o
);
   import radio_frontend_pkg::*;

   iq_phase_e phase_q;     // Phase of the next edge
   dac_word_t hold_q_q;    // Q word for the second half

   // Phase register, first edge out of reset is an I edge
   always_ff @(posedge dsp_clk)
   begin
      if (reset_i)
      begin
         phase_q <= IQ_PHASE_I;
      end
      else if (phase_q == IQ_PHASE_I)
      begin
         phase_q <= IQ_PHASE_Q;
      end
      else
      begin
         phase_q <= IQ_PHASE_I;
      end
   end

   // Keep Q while I is on the pins
   always_ff @(posedge dsp_clk)
   begin
      if (phase_q == IQ_PHASE_I)
      begin
         hold_q_q <= dac_word_t'(dac_q_i);   // Low 12 bits only
      end
   end

   // DAC pins
   always_ff @(posedge dsp_clk)
   begin
      if (reset_i)
      begin
         dac_o       <= '0;
         tx_iq_sel_o <= 1'b1;
      end
      else if (phase_q == IQ_PHASE_I)
      begin
         dac_o       <= dac_word_t'(dac_i_i);
         tx_iq_sel_o <= 1'b0;
      end
      else
      begin
         dac_o       <= hold_q_q;
         tx_iq_sel_o <= 1'b1;
      end
   end

   // Transceiver expects a strict I, Q, I, Q sequence
   // Antecedent on reset keeps the release edge out of the check
   sel_toggle_a : assert property (
      @(posedge dsp_clk) disable iff (reset_i)
      !reset_i |=> tx_iq_sel_o != $past(tx_iq_sel_o)
   );

endmodule

// ==== radio_frontend_pkg.sv ====
//--------------------
// Shared types of the radio front end: sample and pin words,
// the I/Q phase and the SPI device index.
// Modules import it in their body and use scoped names in ports.
//--------------------
package radio_frontend_pkg;

`include "radio_frontend_settings.svh"

   // Pin and sample words
   typedef logic [`RF_ADC_WIDTH-1:0]    adc_word_t;
   typedef logic [`RF_RX_WIDTH-1:0]     rx_sample_t;
   typedef logic [`RF_DAC_IN_WIDTH-1:0] dac_sample_t;
   typedef logic [`RF_DAC_WIDTH-1:0]    dac_word_t;

   // One bit per SPI peripheral
   typedef logic [`RF_SPI_DEVICES-1:0]  spi_sel_t;

   // Which half of an interleaved pair is on the bus
   typedef enum logic
   {
      IQ_PHASE_I = 1'b0,
      IQ_PHASE_Q = 1'b1
   } iq_phase_e;

   // Index into spi_sel_t
   typedef enum logic [3:0]
   {
      SPI_DEV_CLK    = 4'd0,
      SPI_DEV_DAC    = 4'd1,
      SPI_DEV_ADC    = 4'd2,
      SPI_DEV_TX_DB  = 4'd3,
      SPI_DEV_TX_DAC = 4'd4,
      SPI_DEV_TX_ADC = 4'd5,
      SPI_DEV_RX_DB  = 4'd6,
      SPI_DEV_RX_DAC = 4'd7,
      SPI_DEV_RX_ADC = 4'd8
   } spi_dev_e;

endpackage

// ==== radio_frontend_settings.svh ====
//--------------------
// Fixed widths and SPI bus constants of the transceiver front end.
// Include wherever a width or the SPI device layout is needed; the
// package pulls this in for its typedefs.
//--------------------
`ifndef RADIO_FRONTEND_SETTINGS_SVH
`define RADIO_FRONTEND_SETTINGS_SVH

// Receive side
`define RF_ADC_WIDTH     12           // ADC pin word
`define RF_RX_WIDTH      14           // Sample width towards the DSP

// Transmit side
`define RF_DAC_IN_WIDTH  16           // Sample width from the DSP
`define RF_DAC_WIDTH     12           // DAC pin word

// SPI peripherals, bit order follows the device index enum
`define RF_SPI_DEVICES   9

// Devices with a read-back line
//   bit 0 clock gen, bit 1 mainboard DAC,
//   bit 3 TX daughterboard, bit 5 TX daughterboard ADC,
//   bit 6 RX daughterboard, bit 8 RX daughterboard ADC
`define RF_SPI_MISO_MASK 9'h16B

`endif

// ==== radio_frontend_top.f ====
+incdir+.
radio_frontend_pkg.sv
lms_rx_deinterleave.sv
lms_tx_interleave.sv
spi_bus_fanout.sv
radio_frontend_top.sv
tb_radio_frontend_top.sv

// ==== radio_frontend_top.sv ====
//--------------------
// Radio front-end glue between the DSP core and the integrated
// RF transceiver: receive deinterleave, transmit interleave and
// the SPI fan-out, all on dsp_clk.
//--------------------
module radio_frontend_top
(
   input  logic                            dsp_clk,
   input  logic                            reset_i,

   // Receive ADC pins and samples
   input  radio_frontend_pkg::adc_word_t   adc0_i,
   input  radio_frontend_pkg::adc_word_t   adc1_i,
   output logic                            rx_iq_sel0_o,
   output logic                            rx_iq_sel1_o,
   output radio_frontend_pkg::rx_sample_t  adc_i0_o,
   output radio_frontend_pkg::rx_sample_t  adc_q0_o,
   output radio_frontend_pkg::rx_sample_t  adc_i1_o,
   output radio_frontend_pkg::rx_sample_t  adc_q1_o,
   output logic                            adc_strobe_o,

   // Transmit samples and DAC pins
   input  radio_frontend_pkg::dac_sample_t dac_i_i,
   input  radio_frontend_pkg::dac_sample_t dac_q_i,
   output radio_frontend_pkg::dac_word_t   dac_o,
   output logic                            tx_iq_sel_o,

   // SPI master side and peripheral pins
   input  radio_frontend_pkg::spi_sel_t    spi_sen_i,
   input  logic                            spi_sclk_i,
   input  logic                            spi_mosi_i,
   output radio_frontend_pkg::spi_sel_t    spi_dev_sclk_o,
   output radio_frontend_pkg::spi_sel_t    spi_dev_mosi_o,
   input  radio_frontend_pkg::spi_sel_t    spi_dev_miso_i,
   output logic                            spi_miso_o
);

   // Receive path
   lms_rx_deinterleave rx_deint_i
   (
      .dsp_clk      (dsp_clk),
      .reset_i      (reset_i),
      .adc0_i       (adc0_i),
      .adc1_i       (adc1_i),
      .rx_iq_sel0_o (rx_iq_sel0_o),
      .rx_iq_sel1_o (rx_iq_sel1_o),
      .adc_i0_o     (adc_i0_o),
      .adc_q0_o     (adc_q0_o),
      .adc_i1_o     (adc_i1_o),
      .adc_q1_o     (adc_q1_o),
      .adc_strobe_o (adc_strobe_o)
   );

   // Transmit path, rising edge like the rest
   lms_tx_interleave tx_int_i
   (
      .dsp_clk     (dsp_clk),
      .reset_i     (reset_i),
      .dac_i_i     (dac_i_i),
      .dac_q_i     (dac_q_i),
      .dac_o       (dac_o),
      .tx_iq_sel_o (tx_iq_sel_o)
   );

   // SPI fan-out to the nine peripherals
   spi_bus_fanout spi_fanout_i
   (
      .dsp_clk        (dsp_clk),
      .reset_i        (reset_i),
      .spi_sen_i      (spi_sen_i),
      .spi_sclk_i     (spi_sclk_i),
      .spi_mosi_i     (spi_mosi_i),
      .spi_dev_sclk_o (spi_dev_sclk_o),
      .spi_dev_mosi_o (spi_dev_mosi_o),
      .spi_dev_miso_i (spi_dev_miso_i),
      .spi_miso_o     (spi_miso_o)
   );

endmodule

// ==== spi_bus_fanout.sv ====
//--------------------
// Fan-out of one SPI master to the board's nine peripherals.
// Clock and data reach only the device whose active-low enable is
// asserted; read-back lines of the devices that have one are merged.
// Purely combinational, the clock is only for the checker.
//--------------------
`include "radio_frontend_settings.svh"

module spi_bus_fanout
(
   input  logic                         dsp_clk,
   input  logic                         reset_i,
   input  radio_frontend_pkg::spi_sel_t spi_sen_i,
   input  logic                         spi_sclk_i,
   input  logic                         spi_mosi_i,
   output radio_frontend_pkg::spi_sel_t spi_dev_sclk_o,
   output radio_frontend_pkg::spi_sel_t spi_dev_mosi_o,
   input  radio_frontend_pkg::spi_sel_t spi_dev_miso_i,
   output logic                         spi_miso_o
);
   import radio_frontend_pkg::*;

   localparam spi_sel_t MISO_MASK = `RF_SPI_MISO_MASK;

   spi_sel_t dev_active;    // High for the enabled device
   spi_sel_t miso_gated;

   assign dev_active = ~spi_sen_i;

   // Idle devices see a quiet bus
   always_comb
   begin
      for (int k = 0; k < `RF_SPI_DEVICES; k++)
      begin
         spi_dev_sclk_o[k] = dev_active[k] & spi_sclk_i;
         spi_dev_mosi_o[k] = dev_active[k] & spi_mosi_i;
      end
   end

   // Devices without a return line may float, so mask them out
   assign miso_gated = dev_active & spi_dev_miso_i & MISO_MASK;
   assign spi_miso_o = |miso_gated;

   // Two enables at once would short the merged read-back
   one_device_a : assert property (
      @(posedge dsp_clk) disable iff (reset_i)
      $countones(dev_active) <= 1
   );

endmodule

// ==== tb_radio_frontend_top.sv ====
//--------------------
// Directed testbench for the radio front end.
// Runs the reset, receive, transmit and SPI fan-out tests in turn,
// prints one line per test and a closing line with the counts.
//--------------------
`include "radio_frontend_settings.svh"

module tb_radio_frontend_top;
   timeunit 1ns;
   timeprecision 1ps;

   import radio_frontend_pkg::*;

   // Tests take about 150 cycles in all
   localparam int TIMEOUT_CYCLES = 400;
   localparam int RX_PAIRS       = 16;
   localparam int TX_PAIRS       = 16;
   localparam int MISO_ROUNDS    = 4;
   localparam int IDLE_ROUNDS    = 8;

   logic        dsp_clk;
   logic        reset_i;
   adc_word_t   adc0_i;
   adc_word_t   adc1_i;
   logic        rx_iq_sel0_o;
   logic        rx_iq_sel1_o;
   rx_sample_t  adc_i0_o;
   rx_sample_t  adc_q0_o;
   rx_sample_t  adc_i1_o;
   rx_sample_t  adc_q1_o;
   logic        adc_strobe_o;
   dac_sample_t dac_i_i;
   dac_sample_t dac_q_i;
   dac_word_t   dac_o;
   logic        tx_iq_sel_o;
   spi_sel_t    spi_sen_i;
   logic        spi_sclk_i;
   logic        spi_mosi_i;
   spi_sel_t    spi_dev_sclk_o;
   spi_sel_t    spi_dev_mosi_o;
   spi_sel_t    spi_dev_miso_i;
   logic        spi_miso_o;

   int          errors = 0;
   int          checks = 0;
   int          tests = 0;
   int          test_first_error = 0;
   int          cycle_count = 0;
   logic [31:0] lcg_state = 32'd3;

   radio_frontend_top dut_i
   (
      .dsp_clk        (dsp_clk),
      .reset_i        (reset_i),
      .adc0_i         (adc0_i),
      .adc1_i         (adc1_i),
      .rx_iq_sel0_o   (rx_iq_sel0_o),
      .rx_iq_sel1_o   (rx_iq_sel1_o),
      .adc_i0_o       (adc_i0_o),
      .adc_q0_o       (adc_q0_o),
      .adc_i1_o       (adc_i1_o),
      .adc_q1_o       (adc_q1_o),
      .adc_strobe_o   (adc_strobe_o),
      .dac_i_i        (dac_i_i),
      .dac_q_i        (dac_q_i),
      .dac_o          (dac_o),
      .tx_iq_sel_o    (tx_iq_sel_o),
      .spi_sen_i      (spi_sen_i),
      .spi_sclk_i     (spi_sclk_i),
      .spi_mosi_i     (spi_mosi_i),
      .spi_dev_sclk_o (spi_dev_sclk_o),
      .spi_dev_mosi_o (spi_dev_mosi_o),
      .spi_dev_miso_i (spi_dev_miso_i),
      .spi_miso_o     (spi_miso_o)
   );

   initial dsp_clk = 1'b0;
   always #2 dsp_clk = ~dsp_clk;     // 4 ns period

   // Watchdog on the cycle count
   always @(posedge dsp_clk)
   begin
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES)
      begin
         $display("Timeout after %0d cycles, a test never completed", cycle_count);
         $display("Regression failed");
         $finish;
      end
   end

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   // Upper LCG bits, the low ones repeat too soon
   function automatic adc_word_t rand_adc();
      logic [31:0] r;
      r = lcg_next();
      return r[27:16];
   endfunction

   function automatic dac_sample_t rand_dac();
      logic [31:0] r;
      r = lcg_next();
      return r[31:16];
   endfunction

   function automatic spi_sel_t rand_sel();
      logic [31:0] r;
      r = lcg_next();
      return r[24:16];
   endfunction

   function automatic rx_sample_t widen_adc(adc_word_t w);
      return {{(`RF_RX_WIDTH - `RF_ADC_WIDTH){1'b0}}, w};
   endfunction

   // Board devices wired with a read-back line
   function automatic logic has_return_line(spi_dev_e dev);
      case (dev)
         SPI_DEV_CLK, SPI_DEV_DAC, SPI_DEV_TX_DB,
         SPI_DEV_TX_ADC, SPI_DEV_RX_DB, SPI_DEV_RX_ADC: return 1'b1;
         default: return 1'b0;
      endcase
   endfunction

   task automatic compare_rx(string name, rx_sample_t got, rx_sample_t expected);
      checks++;
      if (got !== expected)
      begin
         $display("[FAIL] %s got 0x%h expected 0x%h", name, got, expected);
         errors++;
      end
   endtask

   task automatic compare_dac(string name, dac_word_t got, dac_word_t expected);
      checks++;
      if (got !== expected)
      begin
         $display("[FAIL] %s got 0x%h expected 0x%h", name, got, expected);
         errors++;
      end
   endtask

   task automatic compare_sel(string name, spi_sel_t got, spi_sel_t expected);
      checks++;
      if (got !== expected)
      begin
         $display("[FAIL] %s got 0x%h expected 0x%h", name, got, expected);
         errors++;
      end
   endtask

   task automatic compare_bit(string name, logic got, logic expected);
      checks++;
      if (got !== expected)
      begin
         $display("[FAIL] %s got 0x%h expected 0x%h", name, got, expected);
         errors++;
      end
   endtask

   task automatic report_error(string msg);
      $display("Error: %s", msg);
      errors++;
   endtask

   task automatic next_cycle();
      @(posedge dsp_clk);
      #1;
   endtask

   task automatic start_test();
      test_first_error = errors;
   endtask

   task automatic end_test(string name);
      tests++;
      if (errors == test_first_error)
         $display("Test %-20s ok", name);
      else
         $display("Test %-20s %0d errors", name, errors - test_first_error);
   endtask

   task automatic test_reset_state();
      start_test();
      compare_bit("rx_iq_sel0_o", rx_iq_sel0_o, 1'b0);
      compare_bit("rx_iq_sel1_o", rx_iq_sel1_o, 1'b0);
      compare_bit("adc_strobe_o", adc_strobe_o, 1'b0);
      compare_bit("tx_iq_sel_o", tx_iq_sel_o, 1'b1);
      compare_dac("dac_o", dac_o, '0);
      end_test("reset state");
   endtask

   task automatic test_rx_deinterleave();
      adc_word_t  i0;
      adc_word_t  i1;
      adc_word_t  q0;
      adc_word_t  q1;
      rx_sample_t expect_q[$];       // Four words per pair
      logic       exp_sel;
      int         strobes;
      int         last_strobe;
      start_test();
      strobes     = 0;
      last_strobe = -1;
      i0          = '0;
      i1          = '0;
      while (rx_iq_sel0_o)           // Start on an I cycle
         next_cycle();
      exp_sel = 1'b0;
      while (strobes < RX_PAIRS)
      begin
         compare_bit("rx_iq_sel0_o", rx_iq_sel0_o, exp_sel);
         compare_bit("rx_iq_sel1_o", rx_iq_sel1_o, exp_sel);
         if (!rx_iq_sel0_o)
         begin
            i0     = rand_adc();
            i1     = rand_adc();
            adc0_i = i0;
            adc1_i = i1;
         end
         else
         begin
            q0     = rand_adc();
            q1     = rand_adc();
            adc0_i = q0;
            adc1_i = q1;
            expect_q.push_back(widen_adc(i0));
            expect_q.push_back(widen_adc(q0));
            expect_q.push_back(widen_adc(i1));
            expect_q.push_back(widen_adc(q1));
         end
         next_cycle();
         exp_sel = ~exp_sel;
         if (adc_strobe_o)
         begin
            if (expect_q.size() < 4)
               report_error("receive strobe came before a full I/Q pair was driven");
            else
            begin
               compare_rx("adc_i0_o", adc_i0_o, expect_q.pop_front());
               compare_rx("adc_q0_o", adc_q0_o, expect_q.pop_front());
               compare_rx("adc_i1_o", adc_i1_o, expect_q.pop_front());
               compare_rx("adc_q1_o", adc_q1_o, expect_q.pop_front());
            end
            if (last_strobe >= 0 && cycle_count - last_strobe != 2)
               report_error("receive strobes were not two cycles apart");
            last_strobe = cycle_count;
            strobes++;
         end
      end
      end_test("receive deinterleave");
   endtask

   task automatic test_tx_interleave();
      dac_sample_t di;
      dac_sample_t dq;
      start_test();
      while (!tx_iq_sel_o)           // Select high means the next edge takes I
         next_cycle();
      for (int n = 0; n < TX_PAIRS; n++)
      begin
         di      = rand_dac();
         dq      = rand_dac();
         dac_i_i = di;
         dac_q_i = dq;
         next_cycle();
         compare_bit("tx_iq_sel_o", tx_iq_sel_o, 1'b0);
         compare_dac("dac_o", dac_o, di[`RF_DAC_WIDTH-1:0]);
         next_cycle();
         compare_bit("tx_iq_sel_o", tx_iq_sel_o, 1'b1);
         compare_dac("dac_o", dac_o, dq[`RF_DAC_WIDTH-1:0]);
      end
      end_test("transmit interleave");
   endtask

   task automatic test_spi_routing();
      spi_dev_e dev;
      spi_sel_t onehot;
      logic     sclk;
      logic     mosi;
      start_test();
      for (int k = 0; k < `RF_SPI_DEVICES; k++)
      begin
         dev       = spi_dev_e'(k);
         onehot    = spi_sel_t'(1) << k;
         spi_sen_i = ~onehot;        // Active low
         for (int t = 0; t < 4; t++)
         begin
            sclk       = t[0];
            mosi       = t[1];
            spi_sclk_i = sclk;
            spi_mosi_i = mosi;
            #1;
            compare_sel($sformatf("spi_dev_sclk_o %s", dev.name()), spi_dev_sclk_o,
                        {`RF_SPI_DEVICES{sclk}} & onehot);
            compare_sel($sformatf("spi_dev_mosi_o %s", dev.name()), spi_dev_mosi_o,
                        {`RF_SPI_DEVICES{mosi}} & onehot);
            next_cycle();
         end
      end
      spi_sen_i  = '1;
      spi_sclk_i = 1'b0;
      spi_mosi_i = 1'b0;
      end_test("SPI routing");
   endtask

   task automatic test_miso_combine();
      spi_dev_e dev;
      spi_sel_t miso;
      start_test();
      for (int k = 0; k < `RF_SPI_DEVICES; k++)
      begin
         dev       = spi_dev_e'(k);
         spi_sen_i = ~(spi_sel_t'(1) << k);
         for (int n = 0; n < MISO_ROUNDS; n++)
         begin
            miso           = rand_sel();
            miso[k]        = n[0];       // Selected line seen both low and high
            spi_dev_miso_i = miso;
            #1;
            compare_bit($sformatf("spi_miso_o %s", dev.name()), spi_miso_o,
                        has_return_line(dev) ? miso[k] : 1'b0);
            next_cycle();
         end
      end
      spi_sen_i = '1;
      end_test("read-back combining");
   endtask

   task automatic test_idle_bus();
      start_test();
      spi_sen_i = '1;
      for (int n = 0; n < IDLE_ROUNDS; n++)
      begin
         spi_sclk_i     = n[0];      // Every clock and data combination
         spi_mosi_i     = n[1];
         spi_dev_miso_i = rand_sel();
         #1;
         compare_sel("spi_dev_sclk_o", spi_dev_sclk_o, '0);
         compare_sel("spi_dev_mosi_o", spi_dev_mosi_o, '0);
         compare_bit("spi_miso_o", spi_miso_o, 1'b0);
         next_cycle();
      end
      end_test("idle bus");
   endtask

   initial
   begin
      reset_i        = 1'b1;
      adc0_i         = '0;
      adc1_i         = '0;
      dac_i_i        = '0;
      dac_q_i        = '0;
      spi_sen_i      = '1;       // Nothing selected
      spi_sclk_i     = 1'b0;
      spi_mosi_i     = 1'b0;
      spi_dev_miso_i = '0;
      repeat (4) @(posedge dsp_clk);
      #1;
      reset_i = 1'b0;

      test_reset_state();
      test_rx_deinterleave();
      test_tx_interleave();
      test_spi_routing();
      test_miso_combine();
      test_idle_bus();

      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule
